//--- include/bxf_defs.svh
`ifndef BXF_DEFS_SVH
`define BXF_DEFS_SVH

// Window geometry
`define BXF_WIN     17
`define BXF_AREA    289
`define BXF_CENTER  8

// Datapath widths
`define BXF_PIX_W   8
`define BXF_COL_W   13
`define BXF_WIN_W   17

// APB register map
`define BXF_ADDR_W      4
`define BXF_REG_CTRL    4'h0
`define BXF_REG_LINE_LEN 4'h4
`define BXF_REG_BIAS    4'h8
`define BXF_REG_STATUS  4'hC

`endif

//--- hw/bxf_stream_pkg.sv
`include "bxf_defs.svh"

package bxf_stream_pkg;

    typedef logic [`BXF_PIX_W-1:0] pixel_t;

    typedef logic [`BXF_WIN_W-1:0] win_sum_t;

    // Row 0 is the top of the column
    typedef struct packed {
        pixel_t [`BXF_WIN-1:0] row;
    } column_t;

    typedef struct packed {
        logic [`BXF_COL_W-1:0] sum;
        pixel_t                center;
        logic                  valid;
    } col_sum_t;

    typedef struct packed {
        win_sum_t sum;
        pixel_t   center;
        logic     fg;
    } result_t;

endpackage

//--- hw/bxf_reg_pkg.sv
`include "bxf_defs.svh"

package bxf_reg_pkg;

    typedef struct packed {
        logic        en;
        logic [9:0]  line_len;
        logic [15:0] bias;
    } cfg_t;

    // Word index of each register
    typedef enum logic [1:0] {
        REG_CTRL     = 2'(`BXF_REG_CTRL >> 2),
        REG_LINE_LEN = 2'(`BXF_REG_LINE_LEN >> 2),
        REG_BIAS     = 2'(`BXF_REG_BIAS >> 2),
        REG_STATUS   = 2'(`BXF_REG_STATUS >> 2)
    } reg_idx_e;

endpackage

//--- hw/bxf_apb_decode.sv
`timescale 1ns/100ps
`include "bxf_defs.svh"

module bxf_apb_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_psel,
    input  logic                    i_penable,
    input  logic                    i_pwrite,
    input  logic [`BXF_ADDR_W-1:0]  i_paddr,
    input  logic [31:0]             i_pwdata,
    input  logic                    i_res_pulse,
    output logic [31:0]             o_prdata,
    output logic                    o_pready,
    output logic                    o_pslverr,
    output bxf_reg_pkg::cfg_t       o_cfg
);

    logic                  access;
    logic                  aligned;
    logic                  bad_len;
    logic                  err;
    logic [15:0]           status;
    bxf_reg_pkg::reg_idx_e idx;

    assign access  = i_psel & i_penable;
    assign idx     = bxf_reg_pkg::reg_idx_e'(i_paddr[`BXF_ADDR_W-1:2]);
    assign aligned = (i_paddr[1:0] == 2'b00);
    assign bad_len = (i_pwdata[9:0] < 10'(`BXF_WIN));

    assign err = !aligned
        || (i_pwrite && (idx == bxf_reg_pkg::REG_STATUS))
        || (i_pwrite && (idx == bxf_reg_pkg::REG_LINE_LEN) && bad_len);

    // Zero wait states
    assign o_pready  = 1'b1;
    assign o_pslverr = access & err;

    always_comb begin
        o_prdata = '0;
        if (aligned) begin
            case (idx)
                bxf_reg_pkg::REG_CTRL:     o_prdata = {31'b0, o_cfg.en};
                bxf_reg_pkg::REG_LINE_LEN: o_prdata = {22'b0, o_cfg.line_len};
                bxf_reg_pkg::REG_BIAS:     o_prdata = {16'b0, o_cfg.bias};
                default:                   o_prdata = {16'b0, status};
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_cfg.en       <= 1'b0;
            o_cfg.line_len <= 10'(`BXF_WIN);
            o_cfg.bias     <= '0;
        end else if (access && i_pwrite && !err) begin
            case (idx)
                bxf_reg_pkg::REG_CTRL:     o_cfg.en       <= i_pwdata[0];
                bxf_reg_pkg::REG_LINE_LEN: o_cfg.line_len <= i_pwdata[9:0];
                bxf_reg_pkg::REG_BIAS:     o_cfg.bias     <= i_pwdata[15:0];
                default: ;
            endcase
        end
    end

    // Results produced, wraps at 16 bits
    always_ff @(posedge clk) begin
        if (rst) begin
            status <= '0;
        end else if (i_res_pulse) begin
            status <= status + 16'd1;
        end
    end

    // Access phase only after a setup phase
    a_apb_phase: assert property (@(posedge clk) disable iff (rst)
        i_penable |-> i_psel && $past(i_psel && !i_penable));

endmodule

//--- hw/bxf_col_adder_tree.sv
`timescale 1ns/100ps
`include "bxf_defs.svh"

module bxf_col_adder_tree (
    input  logic                     clk,
    input  logic                     rst,
    input  bxf_stream_pkg::column_t  i_col,
    input  logic                     i_valid,
    output bxf_stream_pkg::col_sum_t o_col_sum
);

    localparam int LVLS = 5;

    logic [8:0]            lvl1 [8];
    logic [9:0]            lvl2 [4];
    logic [10:0]           lvl3 [2];
    logic [11:0]           lvl4;
    logic [`BXF_COL_W-1:0] lvl5;
    logic [LVLS-1:0]       vld_pipe;

    bxf_stream_pkg::pixel_t last_row [LVLS-1];
    bxf_stream_pkg::pixel_t ctr_pipe [LVLS];

    ////////////////////////////////////////////////////////////////////////////
    // Pairwise reduction of rows 0 to 15, then row 16 joins
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        for (int i = 0; i < 8; i++) begin
            lvl1[i] <= {1'b0, i_col.row[2*i]} + {1'b0, i_col.row[2*i+1]};
        end
        for (int i = 0; i < 4; i++) begin
            lvl2[i] <= {1'b0, lvl1[2*i]} + {1'b0, lvl1[2*i+1]};
        end
        for (int i = 0; i < 2; i++) begin
            lvl3[i] <= {1'b0, lvl2[2*i]} + {1'b0, lvl2[2*i+1]};
        end
        lvl4 <= {1'b0, lvl3[0]} + {1'b0, lvl3[1]};
        lvl5 <= {1'b0, lvl4} + `BXF_COL_W'(last_row[LVLS-2]);

        // Odd row waits four levels
        last_row[0] <= i_col.row[`BXF_WIN-1];
        for (int i = 1; i < LVLS - 1; i++) begin
            last_row[i] <= last_row[i-1];
        end

        ctr_pipe[0] <= i_col.row[`BXF_CENTER];
        for (int i = 1; i < LVLS; i++) begin
            ctr_pipe[i] <= ctr_pipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[LVLS-2:0], i_valid};
        end
    end

    assign o_col_sum.sum    = lvl5;
    assign o_col_sum.center = ctr_pipe[LVLS-1];
    assign o_col_sum.valid  = vld_pipe[LVLS-1];

endmodule

//--- hw/bxf_delay_line.sv
`timescale 1ns/100ps

module bxf_delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 2
) (
    input  logic clk,
    input  logic i_en,
    input  T     i_d,
    output T     o_q
);

    T stage [DEPTH];

    // Advances on valid beats only
    always_ff @(posedge clk) begin
        if (i_en) begin
            stage[0] <= i_d;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign o_q = stage[DEPTH-1];

endmodule

//--- hw/bxf_window_sum.sv
`timescale 1ns/100ps
`include "bxf_defs.svh"

module bxf_window_sum (
    input  logic                     clk,
    input  logic                     rst,
    input  bxf_stream_pkg::col_sum_t i_col_sum,
    input  bxf_reg_pkg::cfg_t        i_cfg,
    output bxf_stream_pkg::win_sum_t o_sum,
    output bxf_stream_pkg::pixel_t   o_center,
    output logic                     o_full
);

    localparam int SUM_W   = `BXF_WIN_W + 1;
    localparam int MAX_SUM = `BXF_AREA * ((1 << `BXF_PIX_W) - 1);

    logic                     beat;
    logic [9:0]               col_idx;
    logic [SUM_W-1:0]         sum_next;
    bxf_stream_pkg::col_sum_t old_col;
    bxf_stream_pkg::pixel_t   mid_pix;

    assign beat = i_col_sum.valid & i_cfg.en;

    // Column index within the line
    always_ff @(posedge clk) begin
        if (rst || !i_cfg.en) begin
            col_idx <= '0;
        end else if (beat) begin
            if (col_idx == i_cfg.line_len - 10'd1) begin
                col_idx <= '0;
            end else begin
                col_idx <= col_idx + 10'd1;
            end
        end
    end

    bxf_delay_line #(
        .T     (bxf_stream_pkg::col_sum_t),
        .DEPTH (`BXF_WIN)
    ) i_col_hist (
        .clk  (clk),
        .i_en (beat),
        .i_d  (i_col_sum),
        .o_q  (old_col)
    );

    // Middle column of the window
    bxf_delay_line #(
        .T     (bxf_stream_pkg::pixel_t),
        .DEPTH (`BXF_CENTER)
    ) i_ctr_hist (
        .clk  (clk),
        .i_en (beat),
        .i_d  (i_col_sum.center),
        .o_q  (mid_pix)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Running sum over the newest 17 columns of the line
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        if (col_idx == '0) begin
            sum_next = SUM_W'(i_col_sum.sum);
        end else if (col_idx < 10'(`BXF_WIN)) begin
            sum_next = SUM_W'(o_sum) + SUM_W'(i_col_sum.sum);
        end else begin
            sum_next = SUM_W'(o_sum) + SUM_W'(i_col_sum.sum) - SUM_W'(old_col.sum);
        end
    end

    always_ff @(posedge clk) begin
        if (beat) begin
            o_sum    <= sum_next[`BXF_WIN_W-1:0];
            o_center <= mid_pix;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_full <= 1'b0;
        end else begin
            o_full <= beat && (col_idx >= 10'(`BXF_WIN - 1));
        end
    end

    // Underflow wraps past the top bound as well
    a_sum_range: assert property (@(posedge clk) disable iff (rst)
        beat |=> SUM_W'(o_sum) <= SUM_W'(MAX_SUM) && $past(sum_next) <= SUM_W'(MAX_SUM));

endmodule

//--- hw/bxf_threshold_result.sv
`timescale 1ns/100ps
`include "bxf_defs.svh"

module bxf_threshold_result (
    input  logic                     clk,
    input  logic                     rst,
    input  bxf_stream_pkg::win_sum_t i_sum,
    input  bxf_stream_pkg::pixel_t   i_center,
    input  logic                     i_full,
    input  bxf_reg_pkg::cfg_t        i_cfg,
    output bxf_stream_pkg::result_t  o_res,
    output logic                     o_res_valid,
    output logic                     o_res_pulse
);

    localparam int CMP_W = `BXF_WIN_W + 1;

    logic [CMP_W-1:0] lhs;
    logic [CMP_W-1:0] rhs;

    // Centre scaled by area against local sum plus bias
    assign lhs = CMP_W'(i_center) * CMP_W'(`BXF_AREA);
    assign rhs = CMP_W'(i_sum) + CMP_W'(i_cfg.bias);

    always_ff @(posedge clk) begin
        o_res.sum    <= i_sum;
        o_res.center <= i_center;
        o_res.fg     <= (lhs > rhs);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_res_valid <= 1'b0;
        end else begin
            o_res_valid <= i_full & i_cfg.en;
        end
    end

    // One count per result for STATUS
    assign o_res_pulse = o_res_valid;

    a_no_res_disabled: assert property (@(posedge clk) disable iff (rst)
        o_res_valid |-> i_cfg.en);

endmodule

//--- hw/bxf_top.sv
`timescale 1ns/100ps
`include "bxf_defs.svh"

module bxf_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_psel,
    input  logic                    i_penable,
    input  logic                    i_pwrite,
    input  logic [`BXF_ADDR_W-1:0]  i_paddr,
    input  logic [31:0]             i_pwdata,
    output logic [31:0]             o_prdata,
    output logic                    o_pready,
    output logic                    o_pslverr,
    input  bxf_stream_pkg::column_t i_col,
    input  logic                    i_col_valid,
    output bxf_stream_pkg::result_t o_res,
    output logic                    o_res_valid
);

    bxf_reg_pkg::cfg_t        cfg;
    bxf_stream_pkg::col_sum_t col_sum;
    bxf_stream_pkg::win_sum_t win_sum;
    bxf_stream_pkg::pixel_t   center;
    logic                     full;
    logic                     res_pulse;

    bxf_apb_decode i_decode (
        .clk         (clk),
        .rst         (rst),
        .i_psel      (i_psel),
        .i_penable   (i_penable),
        .i_pwrite    (i_pwrite),
        .i_paddr     (i_paddr),
        .i_pwdata    (i_pwdata),
        .i_res_pulse (res_pulse),
        .o_prdata    (o_prdata),
        .o_pready    (o_pready),
        .o_pslverr   (o_pslverr),
        .o_cfg       (cfg)
    );

    bxf_col_adder_tree i_tree (
        .clk       (clk),
        .rst       (rst),
        .i_col     (i_col),
        .i_valid   (i_col_valid),
        .o_col_sum (col_sum)
    );

    bxf_window_sum i_win (
        .clk       (clk),
        .rst       (rst),
        .i_col_sum (col_sum),
        .i_cfg     (cfg),
        .o_sum     (win_sum),
        .o_center  (center),
        .o_full    (full)
    );

    bxf_threshold_result i_result (
        .clk         (clk),
        .rst         (rst),
        .i_sum       (win_sum),
        .i_center    (center),
        .i_full      (full),
        .i_cfg       (cfg),
        .o_res       (o_res),
        .o_res_valid (o_res_valid),
        .o_res_pulse (res_pulse)
    );

endmodule

//--- test/bxf_tb.sv
`timescale 1ns/100ps
`include "bxf_defs.svh"

module bxf_tb;

    localparam int LATENCY     = 7;
    localparam int LINES       = 3;
    localparam int LEN_A       = 17;
    localparam int LEN_B       = 40;
    localparam int OFF_BEATS   = 30;
    localparam int TOTAL_BEATS = LINES * LEN_A + LINES * LEN_B + OFF_BEATS + LEN_B;
    localparam int CYCLE_LIMIT = 2 * TOTAL_BEATS + 200;
    localparam int DRAIN       = 10;
    localparam logic [15:0] BIG_BIAS = 16'h6000;

    typedef struct packed {
        int                       due;
        bxf_stream_pkg::win_sum_t sum;
        bxf_stream_pkg::pixel_t   center;
        logic                     fg;
    } expect_t;

    logic                    clk;
    logic                    rst;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`BXF_ADDR_W-1:0]  paddr;
    logic [31:0]             pwdata;
    logic [31:0]             prdata;
    logic                    pready;
    logic                    pslverr;
    bxf_stream_pkg::column_t col;
    logic                    col_valid;
    bxf_stream_pkg::result_t res;
    logic                    res_valid;

    int          cyc = 0;
    int          err_count = 0;
    int          res_seen = 0;
    int          exp_total;
    expect_t     exp_q[$];
    expect_t     exp_cur = '0;
    logic        exp_valid = 1'b0;
    logic        apb_chk = 1'b0;
    logic        apb_rd_chk = 1'b0;
    logic        exp_err = 1'b0;
    logic [31:0] exp_rdata = '0;

    // Reference model state
    logic        model_en;
    logic [15:0] model_bias;
    int          model_len;
    int          col_pos;
    int          line_sum [1024];
    int          line_ctr [1024];

    bxf_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .i_psel      (psel),
        .i_penable   (penable),
        .i_pwrite    (pwrite),
        .i_paddr     (paddr),
        .i_pwdata    (pwdata),
        .o_prdata    (prdata),
        .o_pready    (pready),
        .o_pslverr   (pslverr),
        .i_col       (col),
        .i_col_valid (col_valid),
        .o_res       (res),
        .o_res_valid (res_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (res_valid) begin
            res_seen <= res_seen + 1;
        end
    end

    initial begin
        wait (cyc >= CYCLE_LIMIT);
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Result: FAILED");
        $finish;
    end

    // Expected result due in the cycle that follows
    always @(negedge clk) begin
        exp_valid = 1'b0;
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            exp_cur   = exp_q.pop_front();
            exp_valid = 1'b1;
        end
    end

    task automatic value_error(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        err_count++;
        $display("** Error: %s expected 0x%h actual 0x%h (cycle %0d)", name, exp_v, act_v, cyc);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////
    a_res_valid: assert property (@(posedge clk) disable iff (rst) res_valid == exp_valid)
        else value_error("o_res_valid", 32'(exp_valid), 32'($sampled(res_valid)));
    a_res_sum: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> res.sum == exp_cur.sum)
        else value_error("o_res.sum", 32'(exp_cur.sum), 32'($sampled(res.sum)));
    a_res_center: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> res.center == exp_cur.center)
        else value_error("o_res.center", 32'(exp_cur.center), 32'($sampled(res.center)));
    a_res_fg: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> res.fg == exp_cur.fg)
        else value_error("o_res.fg", 32'(exp_cur.fg), 32'($sampled(res.fg)));
    a_pready: assert property (@(posedge clk) apb_chk |-> pready)
        else value_error("o_pready", 32'h1, 32'($sampled(pready)));
    a_pslverr: assert property (@(posedge clk) apb_chk |-> pslverr == exp_err)
        else value_error("o_pslverr", 32'(exp_err), 32'($sampled(pslverr)));
    a_prdata: assert property (@(posedge clk) apb_rd_chk |-> prdata == exp_rdata)
        else value_error("o_prdata", exp_rdata, $sampled(prdata));

    task automatic apb_xfer(input logic wr, input logic [`BXF_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, input logic chk_rd,
                            input logic [31:0] rdata, input logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable    = 1'b1;
        apb_chk    = 1'b1;
        apb_rd_chk = chk_rd;
        exp_err    = err;
        exp_rdata  = rdata;
        @(negedge clk);
        psel       = 1'b0;
        penable    = 1'b0;
        apb_chk    = 1'b0;
        apb_rd_chk = 1'b0;
    endtask

    task automatic reg_write(input logic [`BXF_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic err);
        apb_xfer(1'b1, addr, data, 1'b0, '0, err);
    endtask

    task automatic reg_read(input logic [`BXF_ADDR_W-1:0] addr, input logic [31:0] data);
        apb_xfer(1'b0, addr, '0, 1'b1, data, 1'b0);
    endtask

    // Window sum, centre and foreground per line rules
    task automatic model_beat(input bxf_stream_pkg::column_t c);
        int      s;
        int      ctr;
        expect_t e;
        if (!model_en) begin
            return;
        end
        s = 0;
        for (int r = 0; r < `BXF_WIN; r++) begin
            s = s + int'(c.row[r]);
        end
        line_sum[col_pos] = s;
        line_ctr[col_pos] = int'(c.row[`BXF_CENTER]);
        if (col_pos >= `BXF_WIN - 1) begin
            s = 0;
            for (int j = col_pos - (`BXF_WIN - 1); j <= col_pos; j++) begin
                s = s + line_sum[j];
            end
            ctr      = line_ctr[col_pos - `BXF_CENTER];
            e.due    = cyc + LATENCY;
            e.sum    = `BXF_WIN_W'(s);
            e.center = `BXF_PIX_W'(ctr);
            e.fg     = (ctr * `BXF_AREA) > (s + int'(model_bias));
            exp_q.push_back(e);
        end
        col_pos = (col_pos + 1 == model_len) ? 0 : col_pos + 1;
    endtask

    task automatic send_beats(input int n);
        int sent;
        sent = 0;
        while (sent < n) begin
            @(negedge clk);
            col_valid = (($urandom % 4) != 0);
            for (int r = 0; r < `BXF_WIN; r++) begin
                col.row[r] = 8'($urandom);
            end
            if (col_valid) begin
                model_beat(col);
                sent++;
            end
        end
        @(negedge clk);
        col_valid = 1'b0;
    endtask

    task automatic drain();
        repeat (DRAIN) begin
            @(negedge clk);
            col_valid = 1'b0;
        end
    endtask

    // Pipeline is emptied before enable changes
    task automatic set_enable(input logic en);
        drain();
        reg_write(`BXF_REG_CTRL, {31'b0, en}, 1'b0);
        model_en = en;
        col_pos  = 0;
    endtask

    task automatic set_line(input int len, input logic [15:0] bias);
        reg_write(`BXF_REG_LINE_LEN, 32'(len), 1'b0);
        reg_write(`BXF_REG_BIAS, {16'b0, bias}, 1'b0);
        model_len  = len;
        model_bias = bias;
    endtask

    initial begin
        void'($urandom(32'h9bb5441b));
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        col        = '0;
        col_valid  = 1'b0;
        model_en   = 1'b0;
        model_bias = '0;
        model_len  = LEN_A;
        col_pos    = 0;
        exp_total  = LINES * (LEN_A - 16) + LINES * (LEN_B - 16) + (LEN_B - 16);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset values and read back
        reg_read(`BXF_REG_CTRL, 32'h0);
        reg_read(`BXF_REG_LINE_LEN, 32'd17);
        reg_read(`BXF_REG_BIAS, 32'h0);
        reg_read(`BXF_REG_STATUS, 32'h0);
        reg_write(`BXF_REG_BIAS, 32'h0000_abcd, 1'b0);
        reg_read(`BXF_REG_BIAS, 32'h0000_abcd);
        reg_write(`BXF_REG_LINE_LEN, 32'd40, 1'b0);
        reg_read(`BXF_REG_LINE_LEN, 32'd40);
        reg_write(`BXF_REG_CTRL, 32'h1, 1'b0);
        reg_read(`BXF_REG_CTRL, 32'h1);
        reg_write(`BXF_REG_CTRL, 32'h0, 1'b0);

        // Rejected accesses
        reg_write(`BXF_REG_LINE_LEN, 32'd16, 1'b1);
        reg_read(`BXF_REG_LINE_LEN, 32'd40);
        reg_write(`BXF_REG_STATUS, 32'h5, 1'b1);
        reg_read(`BXF_REG_STATUS, 32'h0);
        reg_write(4'h6, 32'hffff, 1'b1);
        reg_read(`BXF_REG_LINE_LEN, 32'd40);
        apb_xfer(1'b0, 4'h3, '0, 1'b0, '0, 1'b1);

        set_line(LEN_A, 16'h0);
        set_enable(1'b1);
        send_beats(LINES * LEN_A);
        set_enable(1'b0);

        set_line(LEN_B, BIG_BIAS);
        set_enable(1'b1);
        send_beats(LINES * LEN_B);
        set_enable(1'b0);

        // Beats while disabled, then a fresh line
        send_beats(OFF_BEATS);
        set_enable(1'b1);
        send_beats(LEN_B);
        drain();
        reg_read(`BXF_REG_STATUS, 32'(exp_total));
        drain();

        a_count: assert (res_seen == exp_total)
            else value_error("result count", 32'(exp_total), 32'(res_seen));
        if (exp_q.size() != 0) begin
            err_count++;
            $display("Error: %0d expected results never appeared", exp_q.size());
        end
        $display("Results seen %0d, errors %0d", res_seen, err_count);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
hw/bxf_stream_pkg.sv
hw/bxf_reg_pkg.sv
hw/bxf_apb_decode.sv
hw/bxf_col_adder_tree.sv
hw/bxf_delay_line.sv
hw/bxf_window_sum.sv
hw/bxf_threshold_result.sv
hw/bxf_top.sv
test/bxf_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= bxf_tb
FILELIST  ?= vlog.f
BUILD     ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Result: PASSED
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard hw/*.sv test/*.sv include/*.svh) $(FILELIST)

.PHONY: run lint clean

run: $(BUILD)/$(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

$(BUILD)/$(TOP): $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD) -o $(TOP)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)
